// File: common/load_pkg.sv
// load unit shared definitions
`default_nettype none

package load_pkg;

  // --------------------------------------------------
  // datapath widths
  // --------------------------------------------------

  // integer register width of the core
  localparam int unsigned XLEN = 64;
  // request address width, physical equals virtual here
  localparam int unsigned ADDR_BITS = 32;
  // scoreboard transaction id carried back with the result
  localparam int unsigned TRANS_ID_BITS = 3;
  // byte offset inside one XLEN word
  localparam int unsigned ALIGN_BITS = $clog2(XLEN / 8);

  // --------------------------------------------------
  // data cache address split
  // --------------------------------------------------

  // index phase sends the low bits
  localparam int unsigned INDEX_WIDTH = 12;
  // tag phase sends the rest, one cycle after the grant
  localparam int unsigned TAG_WIDTH = 20;

  // --------------------------------------------------
  // outstanding-load buffer
  // --------------------------------------------------

  // number of loads that may be in flight
  localparam int unsigned NR_LDBUF = 4;
  // cache request id selects one buffer slot
  localparam int unsigned LDBUF_ID_BITS = $clog2(NR_LDBUF);

  // integer load kinds
  // signed kinds extend the top bit of the field, unsigned kinds zero fill
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } ld_op_e;

  // one tracked load, everything needed to build the result later
  typedef struct packed {
    // scoreboard id of the load
    logic [TRANS_ID_BITS-1:0] trans_id;
    // low address bits, byte position of the field
    logic [ALIGN_BITS-1:0]    offset;
    // kind of load, selects width and extension
    ld_op_e                   op;
  } ldbuf_entry_t;

endpackage

`default_nettype wire

// File: load_req/ld_req_ctrl.sv
// load request controller
`timescale 1ns/100ps
`default_nettype none

module ld_req_ctrl (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  // request from the issue side
  input  logic                                 valid_i,
  input  logic [load_pkg::ADDR_BITS-1:0]       vaddr_i,
  input  logic [load_pkg::TRANS_ID_BITS-1:0]   trans_id_i,
  input  load_pkg::ld_op_e                     op_i,
  input  logic [7:0]                           be_i,
  // cache grant and buffer status
  input  logic                                 data_gnt_i,
  input  logic                                 full_i,
  input  logic [load_pkg::LDBUF_ID_BITS-1:0]   alloc_id_i,
  // request handshake back
  output logic                                 ready_o,
  // cache index phase
  output logic                                 data_req_o,
  output logic [load_pkg::INDEX_WIDTH-1:0]     index_o,
  output logic [7:0]                           be_o,
  output logic [1:0]                           size_o,
  output logic [load_pkg::LDBUF_ID_BITS-1:0]   req_id_o,
  // cache tag phase
  output logic                                 tag_valid_o,
  output logic [load_pkg::TAG_WIDTH-1:0]       tag_o,
  output logic                                 kill_req_o,
  // buffer allocation
  output logic                                 alloc_o,
  output load_pkg::ldbuf_entry_t               alloc_entry_o
);
  import load_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    FLUSH_KILL
  } state_e;

  state_e               state_q, state_d;
  logic                 accept;
  logic [TAG_WIDTH-1:0] tag_q;

  // --------------------------------------------------
  // index phase fields
  // --------------------------------------------------
  // low address bits go out with the request
  assign index_o  = vaddr_i[INDEX_WIDTH-1:0];
  assign be_o     = be_i;
  // cache id is the slot the load will occupy
  assign req_id_o = alloc_id_i;

  // transfer size from the load kind
  always_comb begin
    unique case (op_i)
      LW, LWU: size_o = 2'b10;
      LH, LHU: size_o = 2'b01;
      LB, LBU: size_o = 2'b00;
      default: size_o = 2'b11;
    endcase
  end

  // a new load may start only with a free slot
  assign accept = valid_i && !full_i;

  // --------------------------------------------------
  // request FSM
  // --------------------------------------------------
  always_comb begin
    state_d     = state_q;
    data_req_o  = 1'b0;
    tag_valid_o = 1'b0;
    kill_req_o  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (accept) begin
          data_req_o = 1'b1;
          state_d    = data_gnt_i ? SEND_TAG : WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        // hold the request and the index until granted
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          state_d = SEND_TAG;
        end
      end
      SEND_TAG: begin
        tag_valid_o = 1'b1;
        // load granted last cycle is dropped by a flush now
        kill_req_o  = flush_i;
        state_d     = IDLE;
        // back-to-back request overlaps the tag phase
        if (accept) begin
          data_req_o = 1'b1;
          state_d    = data_gnt_i ? SEND_TAG : WAIT_GNT;
        end
      end
      FLUSH_KILL: begin
        // kill whatever tag the cache may still expect
        tag_valid_o = 1'b1;
        kill_req_o  = 1'b1;
        state_d     = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // flush wins, no request goes out and the next cycle kills
    if (flush_i) begin
      data_req_o = 1'b0;
      state_d    = FLUSH_KILL;
    end
  end

  // request taken by the cache is the request accepted from outside
  assign ready_o = data_req_o && data_gnt_i;
  assign alloc_o = ready_o;

  // entry keeps what the aligner needs when the word returns
  assign alloc_entry_o.trans_id = trans_id_i;
  assign alloc_entry_o.offset   = vaddr_i[ALIGN_BITS-1:0];
  assign alloc_entry_o.op       = op_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // upper address, sent in the tag phase one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      tag_q <= vaddr_i[INDEX_WIDTH+TAG_WIDTH-1:INDEX_WIDTH];
    end
  end

  assign tag_o = tag_q;

endmodule

`default_nettype wire

// File: load_buf/ld_buffer.sv
// outstanding load buffer
`timescale 1ns/100ps
`default_nettype none

module ld_buffer (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  // new load from the controller
  input  logic                                 alloc_i,
  input  load_pkg::ldbuf_entry_t               alloc_entry_i,
  // tag phase kill of the last granted load
  input  logic                                 kill_i,
  // cache response
  input  logic                                 data_rvalid_i,
  input  logic [load_pkg::LDBUF_ID_BITS-1:0]   data_rid_i,
  // status to the controller
  output logic                                 full_o,
  output logic [load_pkg::LDBUF_ID_BITS-1:0]   alloc_id_o,
  // looked-up entry to the aligner
  output logic                                 rsp_live_o,
  output load_pkg::ldbuf_entry_t               rsp_entry_o
);
  import load_pkg::*;

  logic [NR_LDBUF-1:0]      valid_q, valid_d;
  logic [NR_LDBUF-1:0]      flushed_q, flushed_d;
  ldbuf_entry_t             entries_q [NR_LDBUF];
  logic [LDBUF_ID_BITS-1:0] last_id_q;

  // --------------------------------------------------
  // free slot search
  // --------------------------------------------------
  // all slots busy, controller must hold off
  assign full_o = &valid_q;

  // lowest free slot, scanned from the top so index 0 wins
  always_comb begin
    alloc_id_o = '0;
    for (int i = NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        alloc_id_o = LDBUF_ID_BITS'(i);
      end
    end
  end

  // --------------------------------------------------
  // flag update
  // --------------------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // every load in flight is dropped
    if (flush_i) begin
      flushed_d = '1;
    end
    // response frees its slot
    if (data_rvalid_i) begin
      valid_d[data_rid_i] = 1'b0;
    end
    // new load starts clean
    if (alloc_i) begin
      valid_d[alloc_id_o]   = 1'b1;
      flushed_d[alloc_id_o] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      last_id_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      // remember which slot the next tag phase belongs to
      if (alloc_i) begin
        last_id_q <= alloc_id_o;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      entries_q[alloc_id_o] <= alloc_entry_i;
    end
  end

  // --------------------------------------------------
  // response lookup
  // --------------------------------------------------
  assign rsp_entry_o = entries_q[data_rid_i];

  // drop flushed loads and the one whose tag is killed right now
  always_comb begin
    rsp_live_o = 1'b0;
    if (data_rvalid_i && valid_q[data_rid_i] && !flushed_q[data_rid_i]) begin
      rsp_live_o = !(kill_i && (last_id_q == data_rid_i));
    end
  end

endmodule

`default_nettype wire

// File: design/ld_align.sv
// load result aligner
`timescale 1ns/100ps
`default_nettype none

module ld_align (
  // looked-up buffer entry
  input  logic                                 rsp_live_i,
  input  load_pkg::ldbuf_entry_t               rsp_entry_i,
  // raw word from the cache
  input  logic [load_pkg::XLEN-1:0]            data_rdata_i,
  // load result
  output logic                                 result_valid_o,
  output logic [load_pkg::TRANS_ID_BITS-1:0]   result_trans_id_o,
  output logic [load_pkg::XLEN-1:0]            result_o
);
  import load_pkg::*;

  logic [XLEN-1:0]       shifted;
  logic [XLEN/8-1:0]     byte_signs;
  logic [ALIGN_BITS-1:0] sign_pos;
  logic                  is_signed;
  logic                  sign_bit;

  // result goes out in the response cycle
  assign result_valid_o    = rsp_live_i;
  assign result_trans_id_o = rsp_entry_i.trans_id;

  // --------------------------------------------------
  // realign
  // --------------------------------------------------
  // field moves down to bit 0, offset in bytes
  assign shifted = data_rdata_i >> {rsp_entry_i.offset, 3'b000};

  // --------------------------------------------------
  // sign bit, in parallel to the shifter
  // --------------------------------------------------
  // msb of every byte of the raw word
  for (genvar i = 0; i < XLEN / 8; i++) begin : gen_byte_signs
    assign byte_signs[i] = data_rdata_i[8*i+7];
  end

  assign is_signed = rsp_entry_i.op inside {LW, LH, LB};

  // byte that holds the top of the accessed field
  always_comb begin
    unique case (rsp_entry_i.op)
      LW, LWU: sign_pos = rsp_entry_i.offset + ALIGN_BITS'(3);
      LH, LHU: sign_pos = rsp_entry_i.offset + ALIGN_BITS'(1);
      default: sign_pos = rsp_entry_i.offset;
    endcase
  end

  // unsigned kinds fill with zeros
  assign sign_bit = is_signed && byte_signs[sign_pos];

  // --------------------------------------------------
  // extension
  // --------------------------------------------------
  always_comb begin
    unique case (rsp_entry_i.op)
      LW, LWU: result_o = {{(XLEN - 32){sign_bit}}, shifted[31:0]};
      LH, LHU: result_o = {{(XLEN - 16){sign_bit}}, shifted[15:0]};
      LB, LBU: result_o = {{(XLEN - 8){sign_bit}}, shifted[7:0]};
      // full doubleword needs no extension
      default: result_o = shifted;
    endcase
  end

endmodule

`default_nettype wire

// File: design/load_unit_top.sv
// load unit top level
`timescale 1ns/100ps
`default_nettype none

module load_unit_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  // load request handshake
  input  logic                                 valid_i,
  input  logic [load_pkg::TRANS_ID_BITS-1:0]   trans_id_i,
  input  logic [load_pkg::ADDR_BITS-1:0]       vaddr_i,
  input  load_pkg::ld_op_e                     op_i,
  input  logic [7:0]                           be_i,
  output logic                                 ready_o,
  // data cache index phase
  output logic                                 data_req_o,
  output logic [load_pkg::INDEX_WIDTH-1:0]     index_o,
  output logic [7:0]                           be_o,
  output logic [1:0]                           size_o,
  output logic [load_pkg::LDBUF_ID_BITS-1:0]   req_id_o,
  input  logic                                 data_gnt_i,
  // data cache tag phase
  output logic                                 tag_valid_o,
  output logic [load_pkg::TAG_WIDTH-1:0]       tag_o,
  output logic                                 kill_req_o,
  // data cache response
  input  logic                                 data_rvalid_i,
  input  logic [load_pkg::LDBUF_ID_BITS-1:0]   data_rid_i,
  input  logic [load_pkg::XLEN-1:0]            data_rdata_i,
  // load result
  output logic                                 result_valid_o,
  output logic [load_pkg::TRANS_ID_BITS-1:0]   result_trans_id_o,
  output logic [load_pkg::XLEN-1:0]            result_o
);
  import load_pkg::*;

  // controller to buffer
  logic                     alloc;
  ldbuf_entry_t             alloc_entry;
  // buffer to controller
  logic                     full;
  logic [LDBUF_ID_BITS-1:0] alloc_id;
  // buffer to aligner
  logic                     rsp_live;
  ldbuf_entry_t             rsp_entry;

  // --------------------------------------------------
  // request side
  // --------------------------------------------------
  ld_req_ctrl u_req_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .valid_i       (valid_i),
    .vaddr_i       (vaddr_i),
    .trans_id_i    (trans_id_i),
    .op_i          (op_i),
    .be_i          (be_i),
    .data_gnt_i    (data_gnt_i),
    .full_i        (full),
    .alloc_id_i    (alloc_id),
    .ready_o       (ready_o),
    .data_req_o    (data_req_o),
    .index_o       (index_o),
    .be_o          (be_o),
    .size_o        (size_o),
    .req_id_o      (req_id_o),
    .tag_valid_o   (tag_valid_o),
    .tag_o         (tag_o),
    .kill_req_o    (kill_req_o),
    .alloc_o       (alloc),
    .alloc_entry_o (alloc_entry)
  );

  // --------------------------------------------------
  // outstanding loads
  // --------------------------------------------------
  // the kill of the tag phase also suppresses a same-cycle response
  ld_buffer u_ld_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .alloc_i       (alloc),
    .alloc_entry_i (alloc_entry),
    .kill_i        (kill_req_o),
    .data_rvalid_i (data_rvalid_i),
    .data_rid_i    (data_rid_i),
    .full_o        (full),
    .alloc_id_o    (alloc_id),
    .rsp_live_o    (rsp_live),
    .rsp_entry_o   (rsp_entry)
  );

  // --------------------------------------------------
  // result side
  // --------------------------------------------------
  ld_align u_ld_align (
    .rsp_live_i        (rsp_live),
    .rsp_entry_i       (rsp_entry),
    .data_rdata_i      (data_rdata_i),
    .result_valid_o    (result_valid_o),
    .result_trans_id_o (result_trans_id_o),
    .result_o          (result_o)
  );

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held low for two rising edges
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/load_unit_props.sv
// load unit protocol properties
`timescale 1ns/100ps
`default_nettype none

module load_unit_props (
  input wire logic                                clk_i,
  input wire logic                                rst_ni,
  input wire logic                                flush_i,
  input wire logic                                ready_i,
  input wire logic                                data_req_i,
  input wire logic                                data_gnt_i,
  input wire logic [load_pkg::INDEX_WIDTH-1:0]    index_i,
  input wire logic                                tag_valid_i
);

  // tag phase follows every grant by one cycle
  a_tag_after_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_i && data_gnt_i) |=> tag_valid_i)
    else $error("tag phase missing one cycle after a grant");

  // tag phase only after a grant or as the flush kill
  a_tag_has_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tag_valid_i |-> ($past(data_req_i && data_gnt_i) || $past(flush_i)))
    else $error("tag phase without a grant or flush before it");

  // ungranted request keeps request and index until granted, a flush may drop it
  a_req_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_i && !data_gnt_i && !flush_i) |=> (flush_i || (data_req_i && $stable(index_i))))
    else $error("cache request dropped or changed before its grant");

  // no load accepted during flush
  a_no_ready_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> !ready_i)
    else $error("load accepted while flush is high");

endmodule

bind load_unit_top load_unit_props u_props (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .flush_i     (flush_i),
  .ready_i     (ready_o),
  .data_req_i  (data_req_o),
  .data_gnt_i  (data_gnt_i),
  .index_i     (index_o),
  .tag_valid_i (tag_valid_o)
);

`default_nettype wire

// File: test/load_unit_tb.sv
// load unit testbench
`timescale 1ns/100ps
`default_nettype none

module load_unit_tb;
  import load_pkg::*;

  localparam int FIELDS   = 7;
  localparam int MAX_RECS = 64;

  logic                     clk_i, rst_ni, flush_i, valid_i, ready_o;
  logic [TRANS_ID_BITS-1:0] trans_id_i;
  logic [ADDR_BITS-1:0]     vaddr_i;
  ld_op_e                   op_i;
  logic [7:0]               be_i, be_o;
  logic                     data_req_o, data_gnt_i, tag_valid_o, kill_req_o;
  logic [INDEX_WIDTH-1:0]   index_o;
  logic [1:0]               size_o;
  logic [LDBUF_ID_BITS-1:0] req_id_o, data_rid_i;
  logic [TAG_WIDTH-1:0]     tag_o, prev_tag;
  logic                     data_rvalid_i, result_valid_o, prev_grant;
  logic [XLEN-1:0]          data_rdata_i, result_o;
  logic [TRANS_ID_BITS-1:0] result_trans_id_o;

  // stimulus, seven words per load
  logic [63:0]              stim [FIELDS*MAX_RECS];
  int                       n_recs, cycle, cur_rec, hold_cycles, err_cnt, chk_cnt;
  bit                       stim_loaded;
  int                       slot_rec [NR_LDBUF];
  logic [NR_LDBUF-1:0]      occ;
  bit                       flushed [MAX_RECS];
  bit                       done [MAX_RECS];
  int                       grants [MAX_RECS];
  // cache model, responses waiting for their cycle
  logic [LDBUF_ID_BITS-1:0] pend_slot [$];
  int                       pend_due [$];
  logic [63:0]              pend_data [$];

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  load_unit_top dut0 (.*);

  function automatic logic [63:0] field(input int r, input int f);
    return stim[r*FIELDS+f];
  endfunction

  function automatic int group_of(input int r);
    logic [63:0] w;
    w = field(r, 0);
    return int'(w[7:0]);
  endfunction

  function automatic logic [7:0] byte_enables(input logic [2:0] op, input logic [2:0] off);
    logic [7:0] m;
    case (op)
      3'd0:       m = 8'hff;
      3'd1, 3'd2: m = 8'h0f;
      3'd3, 3'd4: m = 8'h03;
      default:    m = 8'h01;
    endcase
    return m << off;
  endfunction

  // size code of the cache request, log2 of the bytes read
  function automatic logic [1:0] transfer_size(input logic [2:0] op);
    logic [1:0] s;
    case (op)
      3'd0:       s = 2'd3;
      3'd1, 3'd2: s = 2'd2;
      3'd3, 3'd4: s = 2'd1;
      default:    s = 2'd0;
    endcase
    return s;
  endfunction

  task automatic check_true(input bit cond, input string msg);
    chk_cnt++;
    assert (cond) else begin
      $display("ERROR at %0t ns: %s", $time, msg);
      err_cnt++;
    end
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
    chk_cnt++;
    assert (got === exp) else begin
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  // --------------------------------------------------
  // cache model, grant and response side
  // --------------------------------------------------
  initial begin : cache_drive
    int best;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rid_i    = '0;
    data_rdata_i  = '0;
    forever begin
      @(posedge clk_i);
      cycle++;
      #1;
      if (hold_cycles > 0) begin
        data_gnt_i = 1'b0;
        hold_cycles--;
      end else begin
        data_gnt_i = ($urandom() % 4) != 0;
      end
      // oldest due response goes first
      best = -1;
      foreach (pend_due[i]) begin
        if (pend_due[i] <= cycle && (best < 0 || pend_due[i] < pend_due[best])) best = i;
      end
      data_rvalid_i = best >= 0;
      if (best >= 0) begin
        data_rid_i   = pend_slot[best];
        data_rdata_i = pend_data[best];
        pend_slot.delete(best);
        pend_due.delete(best);
        pend_data.delete(best);
      end
    end
  end

  // --------------------------------------------------
  // monitor, all outputs sampled mid-cycle
  // --------------------------------------------------
  always @(negedge clk_i) begin : monitor
    int r;
    logic [63:0] addr_w;
    logic [63:0] kind_w;
    if (rst_ni) begin
      if (prev_grant) begin
        check_true(tag_valid_o, "tag_valid_o low one cycle after a grant");
        check_value(64'(tag_o), 64'(prev_tag), "tag_o");
      end
      // a valid load goes out on a grant unless flushing or all slots are busy
      check_value(64'(ready_o), 64'(valid_i && data_gnt_i && !flush_i && !(&occ)), "ready_o");
      // full buffer holds off new loads
      if (&occ) check_true(!ready_o, "load accepted with four loads outstanding");
      // index phase fields of the load being requested
      if (data_req_o) begin
        addr_w = field(cur_rec, 2);
        kind_w = field(cur_rec, 3);
        check_value(64'(index_o), 64'(addr_w[INDEX_WIDTH-1:0]), "index_o");
        check_value(64'(size_o), 64'(transfer_size(kind_w[2:0])), "size_o");
        // byte enables pass through to the cache
        check_value(64'(be_o), 64'(be_i), "be_o");
        if (data_gnt_i) check_true(!occ[req_id_o], "cache request id names a busy slot");
      end
      if (data_rvalid_i) begin
        r = slot_rec[data_rid_i];
        if (flushed[r]) begin
          check_true(!result_valid_o, "flushed load produced a result");
        end else begin
          check_true(result_valid_o, "result missing for a live load");
          check_value(64'(result_trans_id_o), field(r, 1) & 64'h7, "result trans id");
          check_value(result_o, field(r, 6), "result data");
        end
        done[r] = 1'b1;
        occ[data_rid_i] = 1'b0;
      end else begin
        check_true(!result_valid_o, "result without a cache response");
      end
      prev_grant = data_req_o && data_gnt_i;
      if (prev_grant) begin
        slot_rec[req_id_o] = cur_rec;
        occ[req_id_o]      = 1'b1;
        grants[cur_rec]++;
        prev_tag = vaddr_i[ADDR_BITS-1:INDEX_WIDTH];
        pend_slot.push_back(req_id_o);
        pend_due.push_back(cycle + int'(field(cur_rec, 5) & 64'hff));
        pend_data.push_back(field(cur_rec, 4));
      end
    end
  end

  // drives one load and returns on the negedge where it is accepted
  task automatic issue_load(input int r);
    logic [63:0] w;
    if (group_of(r) == 3) hold_cycles = 6;
    @(posedge clk_i);
    #1;
    cur_rec    = r;
    w          = field(r, 1);
    trans_id_i = w[TRANS_ID_BITS-1:0];
    w          = field(r, 2);
    vaddr_i    = w[ADDR_BITS-1:0];
    w          = field(r, 3);
    op_i       = ld_op_e'(w[2:0]);
    be_i       = byte_enables(w[2:0], vaddr_i[2:0]);
    valid_i    = 1'b1;
    do @(negedge clk_i); while (!ready_o);
  endtask

  task automatic apply_flush(input int first, input int last);
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
    flush_i = 1'b1;
    for (int i = first; i < last; i++) begin
      if (!done[i]) flushed[i] = 1'b1;
    end
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    @(negedge clk_i);
    check_true(tag_valid_o && kill_req_o, "no kill cycle after the flush");
  endtask

  // waits for the group's results and for every slot to drain
  task automatic wait_group(input int first, input int last);
    bit all_done;
    do begin
      @(negedge clk_i);
      all_done = (occ == '0) && (pend_due.size() == 0);
      for (int i = first; i < last; i++) all_done &= done[i];
    end while (!all_done);
    for (int i = first; i < last; i++) begin
      check_true(grants[i] == 1, "load not accepted exactly once");
    end
  endtask

  // watchdog, fifty cycles per load
  initial begin
    wait (stim_loaded);
    repeat (n_recs * 50) @(posedge clk_i);
    $display("watchdog expired, the run did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    int r, grp, first, errs_before;
    void'($urandom(32'hc848ce2a));
    flush_i     = 1'b0;
    valid_i     = 1'b0;
    trans_id_i  = '0;
    vaddr_i     = '0;
    op_i        = LD;
    be_i        = '0;
    occ         = '0;
    prev_grant  = 1'b0;
    prev_tag    = '0;
    hold_cycles = 0;
    $readmemh("test/load_stimulus.txt", stim);
    n_recs = 0;
    while (n_recs < MAX_RECS && !$isunknown(stim[n_recs*FIELDS])) n_recs++;
    stim_loaded = 1'b1;
    check_true(n_recs > 0, "stimulus file is empty or missing");
    @(posedge rst_ni);
    @(negedge clk_i);
    r = 0;
    while (r < n_recs) begin
      grp         = group_of(r);
      first       = r;
      errs_before = err_cnt;
      while (r < n_recs && group_of(r) == grp) begin
        issue_load(r);
        r++;
      end
      // flushed loads stay outstanding while the next group runs
      if (grp == 5) begin
        apply_flush(first, r);
      end else begin
        @(posedge clk_i);
        #1 valid_i = 1'b0;
        wait_group(first, r);
      end
      $display("test %0d finished: %0d loads, %0d errors", grp, r - first,
               err_cnt - errs_before);
    end
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/load_stimulus.txt
// test, trans id, address, kind (0 LD 1 LW 2 LWU 3 LH 4 LHU 5 LB 6 LBU),
// cache word, response delay in cycles, expected result; all hex
01 0 12345000 0 807fc33c9669f00f 3 807fc33c9669f00f
01 1 12345000 1 807fc33c9669f00f 2 ffffffff9669f00f
01 2 12345004 1 807fc33c9669f00f 4 ffffffff807fc33c
01 3 12345004 2 807fc33c9669f00f 1 00000000807fc33c
01 4 12345000 3 807fc33c9669f00f 3 fffffffffffff00f
01 5 12345002 3 807fc33c9669f00f 2 ffffffffffff9669
01 6 12345004 3 807fc33c9669f00f 5 ffffffffffffc33c
01 7 12345006 3 807fc33c9669f00f 2 ffffffffffff807f
01 0 12345002 4 807fc33c9669f00f 3 0000000000009669
01 1 12345000 5 807fc33c9669f00f 2 000000000000000f
01 2 12345001 5 807fc33c9669f00f 4 fffffffffffffff0
01 3 12345003 5 807fc33c9669f00f 2 ffffffffffffff96
01 4 12345007 6 807fc33c9669f00f 3 0000000000000080
02 5 0abcd100 0 0123456789abcdef 0c 0123456789abcdef
02 6 0abcd104 1 0123456789abcdef 09 0000000001234567
02 7 0abcd102 3 0123456789abcdef 06 ffffffffffff89ab
02 0 0abcd101 6 0123456789abcdef 03 00000000000000cd
03 1 7f00f207 5 0123456789abcdef 2 0000000000000001
03 2 7f00f204 4 0123456789abcdef 2 0000000000004567
03 3 7f00f200 2 0123456789abcdef 2 0000000089abcdef
04 4 00fff300 6 807fc33c9669f00f 14 000000000000000f
04 5 00fff302 5 807fc33c9669f00f 14 0000000000000069
04 6 00fff300 4 807fc33c9669f00f 14 000000000000f00f
04 7 00fff300 0 807fc33c9669f00f 14 807fc33c9669f00f
04 0 00fff304 6 807fc33c9669f00f 2 000000000000003c
05 1 55555400 0 807fc33c9669f00f 10 0000000000000000
05 2 55555408 1 807fc33c9669f00f 10 0000000000000000
05 3 55555410 3 807fc33c9669f00f 10 0000000000000000
06 4 abcde506 3 0123456789abcdef 3 0000000000000123
06 5 abcde503 5 0123456789abcdef 3 ffffffffffffff89
06 6 abcde500 1 0123456789abcdef 3 ffffffff89abcdef

// File: filelist.f
common/load_pkg.sv
load_req/ld_req_ctrl.sv
load_buf/ld_buffer.sv
design/ld_align.sv
design/load_unit_top.sv
test/tb_clk_gen.sv
test/load_unit_props.sv
test/load_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the load unit testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module load_unit_tb \
  -f filelist.f -o sim_load_unit &&
./obj_dir/sim_load_unit | tee /dev/stderr | grep -q "NO ERRORS" &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }
